//--- booth_lane.sv
`timescale 1ns/1ns
`default_nettype none
`include "mul_macros.svh"

module booth_lane (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     flush,
  input  wire logic                     start,
  input  wire logic [`MUL_OPW-1:0]      a,
  input  wire logic [`MUL_OPW-1:0]      b,
  input  wire logic                     ack,
  output logic                          idle,
  output logic                          done,
  output logic [2*`MUL_XLEN-1:0]        product
);

  // accumulator holds 34 x 34 bits, window is 34 bits plus the y-1 bit
  localparam int ACC_W = 2 * (`MUL_OPW + 1);
  localparam int WIN_W = `MUL_OPW + 2;
  localparam int CNT_W = $clog2(`MUL_MAX_ITER);

  mul_pkg::lane_state_e state;

  logic [ACC_W-1:0] mcand_q;
  logic [WIN_W-1:0] mplier_q;
  logic [ACC_W-1:0] acc_q;
  logic [CNT_W-1:0] iter_q;

  logic [2:0]       win;
  logic             sel_pos;
  logic             sel_neg;
  logic             sel_dpos;
  logic             sel_dneg;
  logic [ACC_W-1:0] mcand_x2;
  logic [ACC_W-1:0] part;
  logic             part_cin;
  logic             last_iter;

  // digit window {y+1, y, y-1}
  assign win = mplier_q[2:0];

  assign sel_pos  = ~win[2] & (win[1] ^ win[0]);
  assign sel_neg  =  win[2] & (win[1] ^ win[0]);
  assign sel_dpos = ~win[2] &  win[1] &  win[0];
  assign sel_dneg =  win[2] & ~win[1] & ~win[0];

  assign mcand_x2 = {mcand_q[ACC_W-2:0], 1'b0};

  // negative digits take the inverted multiple, the +1 rides on the carry-in
  assign part = ({ACC_W{sel_pos}}  &  mcand_q)
              | ({ACC_W{sel_neg}}  & ~mcand_q)
              | ({ACC_W{sel_dpos}} &  mcand_x2)
              | ({ACC_W{sel_dneg}} & ~mcand_x2);
  assign part_cin = sel_neg | sel_dneg;

  // stop at the digit limit or once no set multiplier bits remain
  assign last_iter = (iter_q == CNT_W'(`MUL_MAX_ITER - 1))
                  || (mplier_q[WIN_W-1:2] == '0);

  // lane control
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state <= mul_pkg::lane_idle;
    end else begin
      case (state)
        mul_pkg::lane_idle: begin
          if (start) begin
            state <= mul_pkg::lane_busy;
          end
        end
        mul_pkg::lane_busy: begin
          if (last_iter) begin
            state <= mul_pkg::lane_done;
          end
        end
        mul_pkg::lane_done: begin
          if (ack) begin
            state <= mul_pkg::lane_idle;
          end
        end
        default: begin
          state <= mul_pkg::lane_idle;
        end
      endcase
    end
  end

  // datapath, loaded on start and stepped once per busy cycle
  always_ff @(posedge clk) begin
    if (start && idle) begin
      mcand_q  <= {{(ACC_W - `MUL_OPW){a[`MUL_OPW-1]}}, a};
      mplier_q <= {b[`MUL_OPW-1], b, 1'b0};
      acc_q    <= '0;
      iter_q   <= '0;
    end else if (state == mul_pkg::lane_busy) begin
      mcand_q  <= {mcand_q[ACC_W-3:0], 2'b00};
      mplier_q <= {2'b00, mplier_q[WIN_W-1:2]};
      acc_q    <= acc_q + part + ACC_W'(part_cin);
      iter_q   <= iter_q + 1'b1;
    end
  end

  assign idle    = (state == mul_pkg::lane_idle);
  assign done    = (state == mul_pkg::lane_done);
  // low 64 bits are exact for the 33 x 33 widened product
  assign product = acc_q[2*`MUL_XLEN-1:0];

  // dispatcher only starts a free lane
  a_start_in_idle : assert property (
    @(posedge clk) disable iff (rst)
    start |-> (state == mul_pkg::lane_idle)
  );

  // retire stage only acks a finished lane
  a_ack_in_done : assert property (
    @(posedge clk) disable iff (rst)
    ack |-> (state == mul_pkg::lane_done)
  );

endmodule

`default_nettype wire

//--- list.f
+incdir+.
mul_pkg.sv
mul_dispatch.sv
booth_lane.sv
mul_retire.sv
mul_unit_top.sv
tb_mul_unit.sv

//--- mul_dispatch.sv
`timescale 1ns/1ns
`default_nettype none
`include "mul_macros.svh"

module mul_dispatch (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          flush,
  input  wire logic                          mul_valid,
  input  wire mul_pkg::mul_op_e              mul_op,
  input  wire logic [`MUL_XLEN-1:0]          multiplicand,
  input  wire logic [`MUL_XLEN-1:0]          multiplier,
  output logic                               mul_ready,
  input  wire logic [`MUL_LANES-1:0]         lane_idle,
  output logic [`MUL_LANES-1:0]              lane_start,
  output logic [`MUL_OPW-1:0]                lane_a,
  output logic [`MUL_OPW-1:0]                lane_b,
  output mul_pkg::mul_op_e                   op_ring [`MUL_LANES]
);

  logic [`MUL_LANE_IDW-1:0] disp_ptr;
  logic                     accept;
  logic                     a_signed;
  logic                     b_signed;

  // next lane in rotation must be free and nothing is taken during flush
  assign mul_ready = lane_idle[disp_ptr] && !flush;
  assign accept    = mul_valid && mul_ready;

  // multiplicand is signed except for mulhu
  assign a_signed = (mul_op != mul_pkg::op_mulhu);

  // multiplier is signed only for mul and mulh
  assign b_signed = (mul_op == mul_pkg::op_mul) || (mul_op == mul_pkg::op_mulh);

  // widen to 33 bits so one signed datapath serves all four forms
  assign lane_a = {a_signed & multiplicand[`MUL_XLEN-1], multiplicand};
  assign lane_b = {b_signed & multiplier[`MUL_XLEN-1], multiplier};

  // one-hot start to the pointed lane while all lanes share the operand buses
  assign lane_start = accept ? (`MUL_LANES'(1) << disp_ptr) : '0;

  // rotation pointer
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      disp_ptr <= '0;
    end else if (accept) begin
      disp_ptr <= disp_ptr + 1'b1;
    end
  end

  // opcode ring with one slot per lane for the retire stage
  always_ff @(posedge clk) begin
    if (accept) begin
      op_ring[disp_ptr] <= mul_op;
    end
  end

  // a started lane has left idle by the next cycle
  a_start_taken : assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst || flush) |-> ($past(lane_start) & lane_idle) == '0
  );

endmodule

`default_nettype wire

//--- mul_macros.svh
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// operand and result width
`define MUL_XLEN 32

// operand after widening by opcode, one extra sign bit
`define MUL_OPW 33

// number of Booth lanes and the width of an index into them
`define MUL_LANES 4
`define MUL_LANE_IDW 2

// radix-4 digits needed to cover the 34-bit widened multiplier
`define MUL_MAX_ITER 17

`endif

//--- mul_pkg.sv
`default_nettype none

package mul_pkg;

  // RV32M multiply opcodes
  typedef enum logic [1:0] {
    op_mul    = 2'b00,
    op_mulh   = 2'b01,
    op_mulhsu = 2'b10,
    op_mulhu  = 2'b11
  } mul_op_e;

  // per-lane control state
  typedef enum logic [1:0] {
    lane_idle = 2'b00,
    lane_busy = 2'b01,
    lane_done = 2'b10
  } lane_state_e;

endpackage

`default_nettype wire

//--- mul_retire.sv
`timescale 1ns/1ns
`default_nettype none
`include "mul_macros.svh"

module mul_retire (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     flush,
  input  wire logic [`MUL_LANES-1:0]    lane_done,
  input  wire logic [2*`MUL_XLEN-1:0]   lane_product [`MUL_LANES],
  input  wire mul_pkg::mul_op_e         op_ring [`MUL_LANES],
  output logic [`MUL_LANES-1:0]         lane_ack,
  output logic                          out_valid,
  output logic [`MUL_XLEN-1:0]          result,
  output mul_pkg::mul_op_e              out_op
);

  logic [`MUL_LANE_IDW-1:0] ret_ptr;
  logic                     fire;
  logic [2*`MUL_XLEN-1:0]   sel_product;
  mul_pkg::mul_op_e         sel_op;

  // only the lane at the pointer may retire so request order holds
  assign fire        = lane_done[ret_ptr] && !flush;
  assign sel_product = lane_product[ret_ptr];
  assign sel_op      = op_ring[ret_ptr];

  // ack frees the lane on the same edge that captures its result
  assign lane_ack = fire ? (`MUL_LANES'(1) << ret_ptr) : '0;

  // rotation pointer
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      ret_ptr <= '0;
    end else if (fire) begin
      ret_ptr <= ret_ptr + 1'b1;
    end
  end

  // one-cycle result strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= fire;
    end
  end

  // low word for mul and high word for the three mulh forms
  always_ff @(posedge clk) begin
    if (fire) begin
      if (sel_op == mul_pkg::op_mul) begin
        result <= sel_product[`MUL_XLEN-1:0];
      end else begin
        result <= sel_product[2*`MUL_XLEN-1:`MUL_XLEN];
      end
      out_op <= sel_op;
    end
  end

  // a finished lane keeps its result until the retire stage takes it
  a_done_held : assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst || flush) |-> ($past(lane_done & ~lane_ack) & ~lane_done) == '0
  );

endmodule

`default_nettype wire

//--- mul_unit_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "mul_macros.svh"

module mul_unit_top (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 flush,
  input  wire logic                 mul_valid,
  input  wire mul_pkg::mul_op_e     mul_op,
  input  wire logic [`MUL_XLEN-1:0] multiplicand,
  input  wire logic [`MUL_XLEN-1:0] multiplier,
  output logic                      mul_ready,
  output logic                      out_valid,
  output logic [`MUL_XLEN-1:0]      result,
  output mul_pkg::mul_op_e          out_op
);

  logic [`MUL_LANES-1:0]   lane_start;
  logic [`MUL_LANES-1:0]   lane_idle;
  logic [`MUL_LANES-1:0]   lane_done;
  logic [`MUL_LANES-1:0]   lane_ack;
  logic [`MUL_OPW-1:0]     lane_a;
  logic [`MUL_OPW-1:0]     lane_b;
  logic [2*`MUL_XLEN-1:0]  lane_product [`MUL_LANES];
  mul_pkg::mul_op_e        op_ring [`MUL_LANES];

  mul_dispatch u_dispatch (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .mul_valid    (mul_valid),
    .mul_op       (mul_op),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .mul_ready    (mul_ready),
    .lane_idle    (lane_idle),
    .lane_start   (lane_start),
    .lane_a       (lane_a),
    .lane_b       (lane_b),
    .op_ring      (op_ring)
  );

  // identical Booth lanes sharing the operand buses
  for (genvar i = 0; i < `MUL_LANES; i++) begin : g_lane
    booth_lane u_lane (
      .clk     (clk),
      .rst     (rst),
      .flush   (flush),
      .start   (lane_start[i]),
      .a       (lane_a),
      .b       (lane_b),
      .ack     (lane_ack[i]),
      .idle    (lane_idle[i]),
      .done    (lane_done[i]),
      .product (lane_product[i])
    );
  end

  mul_retire u_retire (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .lane_done    (lane_done),
    .lane_product (lane_product),
    .op_ring      (op_ring),
    .lane_ack     (lane_ack),
    .out_valid    (out_valid),
    .result       (result),
    .out_op       (out_op)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_mul_unit \
  --Mdir obj_dir \
  -o tb_mul_unit_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_mul_unit_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if ! grep -q "^TEST PASS$" sim.log; then
  echo "simulation did not pass, see sim.log"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation passed"
exit 0

//--- tb_mul_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "mul_macros.svh"

module tb_mul_unit;

  localparam int N_REQ = 550;
  // worst case per request with all lanes queued ahead of it plus slack for gaps and drains
  localparam int WD_CYCLES = N_REQ * (`MUL_MAX_ITER + 4) * `MUL_LANES + 2000;
  // longest time for the lanes to empty once requests stop
  localparam int DRAIN_CYCLES = `MUL_LANES * (`MUL_MAX_ITER + 4);

  logic                  clk;
  logic                  rst;
  logic                  flush;
  logic                  mul_valid;
  mul_pkg::mul_op_e      mul_op;
  logic [`MUL_XLEN-1:0]  multiplicand;
  logic [`MUL_XLEN-1:0]  multiplier;
  logic                  mul_ready;
  logic                  out_valid;
  logic [`MUL_XLEN-1:0]  result;
  mul_pkg::mul_op_e      out_op;

  // model state
  logic [`MUL_XLEN-1:0]  exp_q [$];
  mul_pkg::mul_op_e      op_q [$];
  logic [`MUL_XLEN-1:0]  exp_res;
  mul_pkg::mul_op_e      exp_op;
  int                    accepted;
  int                    retired;
  int                    dropped;
  int                    max_inflight;
  logic                  flush_seen;
  string                 test_name;

  mul_unit_top dut (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .mul_valid    (mul_valid),
    .mul_op       (mul_op),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .mul_ready    (mul_ready),
    .out_valid    (out_valid),
    .result       (result),
    .out_op       (out_op)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_value(string what, logic [31:0] expected, logic [31:0] actual);
    $display("Error: test %s %s expected %08h actual %08h", test_name, what, expected, actual);
    $display("TEST FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_plain(string msg);
    $display("test %s failed: %s", test_name, msg);
    $display("TEST FAIL");
    $fatal(1, "check failed");
  endtask

  // widen both operands to 33 bits by opcode and keep the wanted word of the exact product
  function automatic logic [31:0] model_word(mul_pkg::mul_op_e op, logic [31:0] a,
                                             logic [31:0] b);
    logic signed [65:0] a_w;
    logic signed [65:0] b_w;
    logic signed [65:0] prod;
    if (op == mul_pkg::op_mulhu) begin
      a_w = {34'b0, a};
    end else begin
      a_w = {{34{a[31]}}, a};
    end
    if (op == mul_pkg::op_mul || op == mul_pkg::op_mulh) begin
      b_w = {{34{b[31]}}, b};
    end else begin
      b_w = {34'b0, b};
    end
    prod = a_w * b_w;
    return (op == mul_pkg::op_mul) ? prod[31:0] : prod[63:32];
  endfunction

  // corners a quarter of the time
  function automatic logic [31:0] pick_operand();
    logic [31:0] corners [5];
    corners = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff};
    if (($urandom % 4) == 0) begin
      return corners[$urandom % 5];
    end
    return $urandom;
  endfunction

  function automatic mul_pkg::mul_op_e pick_op();
    logic [1:0] r;
    r = 2'($urandom);
    return mul_pkg::mul_op_e'(r);
  endfunction

  // hold the request until it is taken while flush may land on any waiting cycle
  task automatic issue(mul_pkg::mul_op_e op, logic [31:0] a, logic [31:0] b, int flush_pct);
    logic taken;
    taken = 1'b0;
    mul_valid = 1'b1;
    mul_op = op;
    multiplicand = a;
    multiplier = b;
    while (!taken) begin
      flush = (flush_pct > 0) && (($urandom % 100) < 32'(flush_pct));
      @(negedge clk);
      taken = mul_valid && mul_ready;
      @(posedge clk);
      #1;
      flush = 1'b0;
    end
  endtask

  task automatic idle_cycles(int n, int flush_pct);
    mul_valid = 1'b0;
    repeat (n) begin
      flush = (flush_pct > 0) && (($urandom % 100) < 32'(flush_pct));
      @(posedge clk);
      #1;
      flush = 1'b0;
    end
  endtask

  // missing results show up as a count short of the accepted requests
  task automatic drain();
    int waited;
    idle_cycles(1, 0);
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    idle_cycles(8, 0);
    assert (accepted == retired + dropped)
      else report_value("pulse count", 32'(accepted - dropped), 32'(retired));
  endtask

  // model sampled at the falling edge where everything is settled
  always @(negedge clk) begin
    if (!rst) begin
      if (out_valid) begin
        assert (exp_q.size() != 0) else report_plain("out_valid with no request in flight");
        if (exp_q.size() != 0) begin
          exp_res = exp_q.pop_front();
          exp_op = op_q.pop_front();
          retired++;
          assert (result == exp_res) else report_value("result", exp_res, result);
          assert (out_op == exp_op) else report_value("out_op", 32'(exp_op), 32'(out_op));
        end
      end
      assert (!(flush && mul_ready)) else report_plain("mul_ready high during flush");
      if (flush_seen && !flush) begin
        assert (mul_ready) else report_plain("mul_ready low on the cycle after flush");
      end
      if (flush) begin
        dropped += exp_q.size();
        exp_q.delete();
        op_q.delete();
      end
      if (mul_valid && mul_ready) begin
        exp_q.push_back(model_word(mul_op, multiplicand, multiplier));
        op_q.push_back(mul_op);
        accepted++;
        if (exp_q.size() > max_inflight) begin
          max_inflight = exp_q.size();
        end
      end
      flush_seen = flush;
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    report_plain("watchdog expired before all requests retired");
  end

  initial begin
    void'($urandom(63309));
    rst = 1'b1;
    flush = 1'b0;
    mul_valid = 1'b0;
    mul_op = mul_pkg::op_mul;
    multiplicand = '0;
    multiplier = '0;
    accepted = 0;
    retired = 0;
    dropped = 0;
    max_inflight = 0;
    flush_seen = 1'b0;
    test_name = "reset_idle";
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (4) begin
      @(negedge clk);
      assert (mul_ready && !out_valid) else report_plain("not idle and ready after reset");
      @(posedge clk);
      #1;
    end

    test_name = "opcode_random";
    repeat (200) begin
      issue(pick_op(), pick_operand(), pick_operand(), 0);
      idle_cycles($urandom % 4, 0);
    end
    drain();

    test_name = "back_to_back";
    max_inflight = 0;
    repeat (100) begin
      issue(pick_op(), $urandom, $urandom, 0);
    end
    drain();
    assert (max_inflight >= 2) else report_plain("requests never overlapped");

    // sparse multipliers finish early and are interleaved with full-width ones
    test_name = "early_finish";
    repeat (100) begin
      if ($urandom % 2) begin
        issue(pick_op(), $urandom, 32'(1) << ($urandom % 32), 0);
      end else begin
        issue(pick_op(), $urandom, $urandom | 32'h8000_0000, 0);
      end
      idle_cycles($urandom % 2, 0);
    end
    drain();

    test_name = "flush_random";
    repeat (150) begin
      issue(pick_op(), pick_operand(), pick_operand(), 8);
      idle_cycles($urandom % 3, 8);
    end
    drain();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
